// ==== axi_params.svh ====
`ifndef AXI_PARAMS_SVH
`define AXI_PARAMS_SVH

// ID widths, master index on top of the master ID
`define AXI_ID_BITS 4
`define AXI_MST_BITS 2
`define AXI_IDS_BITS (`AXI_MST_BITS + `AXI_ID_BITS)

`define AXI_RESP_BITS 2

// Port counts
`define AXI_NUM_MST 3
`define AXI_NUM_SLV 7

// Outstanding write bursts per master
`define AXI_PEND_BITS 3

`endif

// ==== logic/axi_b_pkg.sv ====
`include "axi_params.svh"

package axi_b_pkg;

  // Field view of the slave-side ID
  typedef struct packed {
    logic [`AXI_MST_BITS-1:0] mst;  // Target master
    logic [`AXI_ID_BITS-1:0]  id;   // ID as the master issued it
  } b_ids_f_t;

  // Slave-side ID word, raw or split into master index and ID
  typedef union packed {
    logic [`AXI_IDS_BITS-1:0] raw;
    b_ids_f_t                 fld;
  } b_ids_u;

  // B payload as seen by a slave
  typedef struct packed {
    b_ids_u                    ids;
    logic [`AXI_RESP_BITS-1:0] resp;
  } b_slv_t;

  // B payload as seen by a master
  typedef struct packed {
    logic [`AXI_ID_BITS-1:0]   id;
    logic [`AXI_RESP_BITS-1:0] resp;
  } b_mst_t;

  // One master's W channel, last-beat view
  typedef struct packed {
    logic valid;
    logic ready;
    logic last;
  } w_last_t;

  localparam logic [`AXI_RESP_BITS-1:0] resp_okay   = 2'b00;
  localparam logic [`AXI_RESP_BITS-1:0] resp_exokay = 2'b01;
  localparam logic [`AXI_RESP_BITS-1:0] resp_slverr = 2'b10;
  localparam logic [`AXI_RESP_BITS-1:0] resp_decerr = 2'b11;

endpackage

// ==== logic/w_burst_tracker.sv ====
`timescale 1ns/1ns
`include "axi_params.svh"

module w_burst_tracker
  import axi_b_pkg::*;
(
  input  logic                          clk,
  input  logic                          rstn,
  input  w_last_t [`AXI_NUM_MST-1:0]    w_last,
  input  logic    [`AXI_NUM_MST-1:0]    m_done,
  output logic    [`AXI_NUM_MST-1:0]    pending
);

  localparam int num_mst = `AXI_NUM_MST;
  localparam logic [`AXI_PEND_BITS-1:0] cnt_max = '1;

  logic [num_mst-1:0]        w_done;
  logic [`AXI_PEND_BITS-1:0] cnt [num_mst];

  // Last beat accepted on W
  always_comb begin
    for (int m = 0; m < num_mst; m++) begin
      w_done[m]  = w_last[m].valid & w_last[m].ready & w_last[m].last;
      pending[m] = |cnt[m];
    end
  end

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      for (int m = 0; m < num_mst; m++) begin
        cnt[m] <= '0;
      end
    end else begin
      for (int m = 0; m < num_mst; m++) begin
        // Burst in and response out together leave the count as is
        if (w_done[m] && !m_done[m] && cnt[m] != cnt_max) begin
          cnt[m] <= cnt[m] + 1'b1;
        end else if (m_done[m] && !w_done[m] && cnt[m] != '0) begin
          cnt[m] <= cnt[m] - 1'b1;
        end
      end
    end
  end

endmodule

// ==== logic/b_arbiter.sv ====
`timescale 1ns/1ns
`include "axi_params.svh"

module b_arbiter
  import axi_b_pkg::*;
(
  input  logic                          clk,
  input  logic                          rstn,
  input  logic   [`AXI_NUM_SLV-1:0]     s_bvalid,
  input  b_slv_t [`AXI_NUM_SLV-1:0]     s_b,
  output logic   [`AXI_NUM_SLV-1:0]     s_bready,
  input  logic   [`AXI_NUM_MST-1:0]     pending,
  output logic                          grant_valid,
  output b_slv_t                        grant_b,
  input  logic                          grant_ready
);

  localparam int num_slv  = `AXI_NUM_SLV;
  localparam int num_mst  = `AXI_NUM_MST;
  localparam int idx_bits = $clog2(`AXI_NUM_SLV);

  // One-hot lock with the top bit as idle
  localparam logic [num_slv:0] lock_idle = {1'b1, {num_slv{1'b0}}};

  logic [num_slv:0]                lock;
  logic [num_slv:0]                lock_next;
  logic [num_slv-1:0]              elig;
  logic [num_slv-1:0]              xfer;
  logic [idx_bits-1:0]             cur;
  logic [(1<<`AXI_MST_BITS)-1:0]   pend_ext;

  // First eligible slave within span slots after start in ring order
  function automatic logic [num_slv:0] pick(input int unsigned start,
                                            input int unsigned span,
                                            input logic [num_slv-1:0] el);
    logic [num_slv:0] res;
    logic             found;
    int unsigned      idx;
    res   = lock_idle;
    found = 1'b0;
    for (int unsigned k = 1; k <= span; k++) begin
      idx = (start + k) % num_slv;
      if (!found && el[idx]) begin
        res      = '0;
        res[idx] = 1'b1;
        found    = 1'b1;
      end
    end
    return res;
  endfunction

  // Out-of-range masters always count as pending
  always_comb begin
    pend_ext = '1;
    pend_ext[num_mst-1:0] = pending;
    for (int s = 0; s < num_slv; s++) begin
      elig[s] = s_bvalid[s] & pend_ext[s_b[s].ids.fld.mst];
    end
  end

  always_comb begin
    cur = '0;
    for (int s = 0; s < num_slv; s++) begin
      if (lock[s]) cur = idx_bits'(s);
    end
  end

  assign xfer = s_bvalid & s_bready;

  always_comb begin
    lock_next = lock;
    if (lock[num_slv]) begin
      lock_next = pick(num_slv - 1, num_slv, elig);  // Lowest first
    end else if (|xfer || !elig[cur]) begin
      // Current slave done or no longer eligible
      lock_next = pick(cur, num_slv - 1, elig);
    end
  end

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      lock <= lock_idle;
    end else begin
      lock <= lock_next;
    end
  end

  // Forward the locked slave
  always_comb begin
    grant_b          = '0;
    grant_b.resp     = resp_slverr;
    for (int s = 0; s < num_slv; s++) begin
      if (lock[s]) grant_b = s_b[s];
    end
  end

  assign grant_valid = |(lock[num_slv-1:0] & elig);
  assign s_bready    = lock[num_slv-1:0] & elig & {num_slv{grant_ready}};

endmodule

// ==== logic/b_router.sv ====
`timescale 1ns/1ns
`include "axi_params.svh"

module b_router
  import axi_b_pkg::*;
(
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          grant_valid,
  input  b_slv_t                        grant_b,
  output logic                          grant_ready,
  output logic   [`AXI_NUM_MST-1:0]     m_bvalid,
  output b_mst_t [`AXI_NUM_MST-1:0]     m_b,
  input  logic   [`AXI_NUM_MST-1:0]     m_bready,
  output logic   [`AXI_NUM_MST-1:0]     m_done,
  output logic                          decode_err
);

  localparam int num_mst = `AXI_NUM_MST;

  logic [num_mst-1:0] hit;     // Decoded target master
  logic [num_mst-1:0] m_hs;
  logic               in_range;
  logic               accept;

  always_comb begin
    for (int m = 0; m < num_mst; m++) begin
      hit[m] = grant_b.ids.fld.mst == `AXI_MST_BITS'(m);
    end
  end

  assign in_range = |hit;
  assign m_hs     = m_bvalid & m_bready;

  // Register free, or emptied this cycle
  assign grant_ready = in_range ? |(hit & (~m_bvalid | m_hs)) : 1'b1;
  assign accept      = grant_valid & grant_ready;
  assign m_done      = hit & {num_mst{accept}};

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      m_bvalid   <= '0;
      decode_err <= 1'b0;
    end else begin
      m_bvalid   <= (m_bvalid & ~m_hs) | m_done;
      decode_err <= accept & ~in_range;  // Dropped, no master gets it
    end
  end

  // Strip the master index on the way out
  always_ff @(posedge clk) begin
    for (int m = 0; m < num_mst; m++) begin
      if (m_done[m]) begin
        m_b[m].id   <= grant_b.ids.fld.id;
        m_b[m].resp <= grant_b.resp;
      end
    end
  end

endmodule

// ==== logic/axi_b_xbar.sv ====
`timescale 1ns/1ns
`include "axi_params.svh"

module axi_b_xbar
  import axi_b_pkg::*;
(
  input  logic                          clk,
  input  logic                          rstn,
  // Slave side
  input  logic    [`AXI_NUM_SLV-1:0]    s_bvalid,
  input  b_slv_t  [`AXI_NUM_SLV-1:0]    s_b,
  output logic    [`AXI_NUM_SLV-1:0]    s_bready,
  // Master side
  output logic    [`AXI_NUM_MST-1:0]    m_bvalid,
  output b_mst_t  [`AXI_NUM_MST-1:0]    m_b,
  input  logic    [`AXI_NUM_MST-1:0]    m_bready,
  input  w_last_t [`AXI_NUM_MST-1:0]    w_last,
  output logic                          decode_err
);

  logic [`AXI_NUM_MST-1:0] pending;
  logic [`AXI_NUM_MST-1:0] m_done;
  logic                    grant_valid;
  logic                    grant_ready;
  b_slv_t                  grant_b;

  w_burst_tracker u_w_burst_tracker (
    .clk     (clk),
    .rstn    (rstn),
    .w_last  (w_last),
    .m_done  (m_done),
    .pending (pending)
  );

  b_arbiter u_b_arbiter (
    .clk         (clk),
    .rstn        (rstn),
    .s_bvalid    (s_bvalid),
    .s_b         (s_b),
    .s_bready    (s_bready),
    .pending     (pending),
    .grant_valid (grant_valid),
    .grant_b     (grant_b),
    .grant_ready (grant_ready)
  );

  b_router u_b_router (
    .clk         (clk),
    .rstn        (rstn),
    .grant_valid (grant_valid),
    .grant_b     (grant_b),
    .grant_ready (grant_ready),
    .m_bvalid    (m_bvalid),
    .m_b         (m_b),
    .m_bready    (m_bready),
    .m_done      (m_done),
    .decode_err  (decode_err)
  );

endmodule

// ==== tb/axi_b_xbar_asserts.sv ====
`timescale 1ns/1ns
`include "axi_params.svh"

module axi_b_xbar_asserts
  import axi_b_pkg::*;
(
  input logic                          clk,
  input logic                          rstn,
  input logic   [`AXI_NUM_SLV-1:0]     s_bvalid,
  input b_slv_t [`AXI_NUM_SLV-1:0]     s_b,
  input logic   [`AXI_NUM_SLV-1:0]     s_bready,
  input logic   [`AXI_NUM_MST-1:0]     m_bvalid,
  input b_mst_t [`AXI_NUM_MST-1:0]     m_b,
  input logic   [`AXI_NUM_MST-1:0]     m_bready,
  input logic                          decode_err
);

  int n_fail = 0;  // Failed assertion count

  for (genvar s = 0; s < `AXI_NUM_SLV; s++) begin : g_slv
    a_slv_stable: assert property (@(posedge clk) disable iff (!rstn)
      s_bvalid[s] && !s_bready[s] |=> s_bvalid[s] && $stable(s_b[s]))
      else begin
        n_fail++;
        $error("slave %0d dropped or changed its response before acceptance", s);
      end
  end

  for (genvar m = 0; m < `AXI_NUM_MST; m++) begin : g_mst
    a_mst_stable: assert property (@(posedge clk) disable iff (!rstn)
      m_bvalid[m] && !m_bready[m] |=> m_bvalid[m] && $stable(m_b[m]))
      else begin
        n_fail++;
        $error("master %0d response dropped or changed under stall", m);
      end
  end

  // One slave served at a time
  a_one_ready: assert property (@(posedge clk) disable iff (!rstn) $onehot0(s_bready))
    else begin
      n_fail++;
      $error("more than one slave ready");
    end

  a_reset_quiet: assert property (@(posedge clk)
    $rose(rstn) |-> m_bvalid == '0 && s_bready == '0 && !decode_err)
    else begin
      n_fail++;
      $error("outputs active right after reset");
    end

endmodule

bind axi_b_xbar axi_b_xbar_asserts u_asserts (
  .clk        (clk),
  .rstn       (rstn),
  .s_bvalid   (s_bvalid),
  .s_b        (s_b),
  .s_bready   (s_bready),
  .m_bvalid   (m_bvalid),
  .m_b        (m_b),
  .m_bready   (m_bready),
  .decode_err (decode_err)
);

// ==== tb/tb_axi_b_xbar.sv ====
`timescale 1ns/1ns
`include "axi_params.svh"

module tb_axi_b_xbar
  import axi_b_pkg::*;
();

  localparam int num_mst  = `AXI_NUM_MST;
  localparam int num_slv  = `AXI_NUM_SLV;
  localparam int n_ent    = 8;
  localparam int n_raise  = 14;
  localparam int n_deliv  = 12;
  localparam int max_wait = 200;  // Cycles per entry before giving up
  localparam int quiet    = 8;    // Window that must pass without surprises

  typedef struct packed {
    logic [num_mst-1:0][1:0] w_num;     // W bursts per master with master 0 lowest
    logic [5:0]              rdy_hold;  // Cycles with every m_bready low
    logic                    rdy_rand;  // Random stalls afterwards
    logic [1:0]              n_err;     // decode_err pulses due
  } entry_t;

  typedef struct packed {
    logic [3:0] ent;
    logic [2:0] slv;
    b_slv_t     b;
  } raise_t;

  typedef struct packed {
    logic [3:0] ent;
    logic [1:0] mst;
    b_mst_t     b;
  } deliv_t;

  // Routing, gating, release, fairness, back-pressure, decode error, counting
  entry_t entries [n_ent] = '{
    {2'd1, 2'd1, 2'd1, 6'd0,  1'b0, 2'd0},
    {2'd0, 2'd0, 2'd0, 6'd0,  1'b0, 2'd0},
    {2'd0, 2'd1, 2'd0, 6'd0,  1'b0, 2'd0},
    {2'd0, 2'd0, 2'd3, 6'd0,  1'b1, 2'd0},
    {2'd2, 2'd0, 2'd0, 6'd12, 1'b0, 2'd0},
    {2'd0, 2'd0, 2'd0, 6'd0,  1'b1, 2'd2},
    {2'd0, 2'd2, 2'd0, 6'd0,  1'b0, 2'd0},
    {2'd0, 2'd1, 2'd0, 6'd0,  1'b1, 2'd0}
  };

  // Slave-side ID is {master index, master ID}
  raise_t raises [n_raise] = '{
    {4'd0, 3'd0, 6'h25, resp_okay},
    {4'd0, 3'd3, 6'h0a, resp_exokay},
    {4'd0, 3'd6, 6'h13, resp_slverr},
    {4'd1, 3'd2, 6'h17, resp_okay},
    {4'd3, 3'd5, 6'h01, resp_okay},
    {4'd3, 3'd1, 6'h02, resp_exokay},
    {4'd3, 3'd4, 6'h03, resp_slverr},
    {4'd4, 3'd6, 6'h2c, resp_okay},
    {4'd4, 3'd0, 6'h29, resp_slverr},
    {4'd5, 3'd4, 6'h31, resp_decerr},
    {4'd5, 3'd5, 6'h3f, resp_okay},
    {4'd6, 3'd1, 6'h14, resp_okay},
    {4'd6, 3'd2, 6'h15, resp_exokay},
    {4'd6, 3'd3, 6'h16, resp_slverr}
  };

  // Per master in ring order of the slaves
  deliv_t deliveries [n_deliv] = '{
    {4'd0, 2'd2, 4'h5, resp_okay},
    {4'd0, 2'd0, 4'ha, resp_exokay},
    {4'd0, 2'd1, 4'h3, resp_slverr},
    {4'd2, 2'd1, 4'h7, resp_okay},
    {4'd3, 2'd0, 4'h2, resp_exokay},
    {4'd3, 2'd0, 4'h3, resp_slverr},
    {4'd3, 2'd0, 4'h1, resp_okay},
    {4'd4, 2'd2, 4'h9, resp_slverr},
    {4'd4, 2'd2, 4'hc, resp_okay},
    {4'd6, 2'd1, 4'h4, resp_okay},
    {4'd6, 2'd1, 4'h5, resp_exokay},
    {4'd7, 2'd1, 4'h6, resp_slverr}
  };

  logic                   clk;
  logic                   rstn;
  logic    [num_slv-1:0]  s_bvalid;
  b_slv_t  [num_slv-1:0]  s_b;
  logic    [num_slv-1:0]  s_bready;
  logic    [num_mst-1:0]  m_bvalid;
  b_mst_t  [num_mst-1:0]  m_b;
  logic    [num_mst-1:0]  m_bready;
  w_last_t [num_mst-1:0]  w_last;
  logic                   decode_err;

  int seed       = 32'h493b;
  int n_mismatch = 0;
  int n_proto    = 0;
  int n_timeout  = 0;
  int n_assert   = 0;
  int err_seen;
  int exp_pend [num_mst];               // Model of the burst counters

  logic   [num_slv-1:0]  sv_valid;      // Slave model state
  b_slv_t [num_slv-1:0]  sv_b;
  logic   [num_mst-1:0]  held;          // Master stalled with a response last cycle
  b_mst_t [num_mst-1:0]  held_b;
  logic   [n_deliv-1:0]  delivered;

  axi_b_xbar u_axi_b_xbar (
    .clk        (clk),
    .rstn       (rstn),
    .s_bvalid   (s_bvalid),
    .s_b        (s_b),
    .s_bready   (s_bready),
    .m_bvalid   (m_bvalid),
    .m_b        (m_b),
    .m_bready   (m_bready),
    .w_last     (w_last),
    .decode_err (decode_err)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_mst(input string name, input b_mst_t got, input b_mst_t exp);
    if (got !== exp) begin
      n_mismatch++;
      $display("error at %0t: %s got id %h resp %h, expected id %h resp %h",
               $time, name, got.id, got.resp, exp.id, exp.resp);
    end
  endtask

  task automatic check_err(input int got, input int exp);
    if (got != exp) begin
      n_mismatch++;
      $display("error at %0t: decode_err pulses got %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    n_proto++;
    $display("%0t: %s", $time, what);
  endtask

  function automatic int next_delivery(input int e, input int m);
    for (int d = 0; d < n_deliv; d++) begin
      if (!delivered[d] && int'(deliveries[d].ent) == e && int'(deliveries[d].mst) == m) begin
        return d;
      end
    end
    return -1;
  endfunction

  function automatic logic entry_done(input int e);
    logic ok;
    ok = err_seen >= int'(entries[e].n_err);
    for (int d = 0; d < n_deliv; d++) begin
      if (int'(deliveries[d].ent) == e && !delivered[d]) ok = 1'b0;
    end
    return ok;
  endfunction

  // Drive on the falling edge and look ahead to the next rising edge
  task automatic run_cycle(input int e, input int cyc);
    int mst;
    int idx;
    @(negedge clk);
    s_bvalid = sv_valid;
    s_b      = sv_b;
    for (int m = 0; m < num_mst; m++) begin
      if (cyc < int'(entries[e].w_num[m])) begin
        w_last[m] = 3'b111;  // Last beat taken
      end else if (cyc % 2 == 0) begin
        w_last[m] = 3'b110;  // Beat inside a burst
      end else begin
        w_last[m] = 3'b011;  // Last flag without valid
      end
    end
    if (cyc < int'(entries[e].rdy_hold)) begin
      m_bready = '0;
    end else if (entries[e].rdy_rand) begin
      m_bready = num_mst'($random(seed));
    end else begin
      m_bready = '1;
    end
    #1;
    for (int m = 0; m < num_mst; m++) begin
      if (held[m] && !m_bvalid[m]) begin
        report_failure($sformatf("master %0d lost its response while stalled", m));
      end else if (held[m]) begin
        check_mst($sformatf("m_b[%0d] under stall", m), m_b[m], held_b[m]);
      end
      if (m_bvalid[m] && m_bready[m]) begin
        idx = next_delivery(e, m);
        if (idx < 0) begin
          report_failure($sformatf("master %0d got a response it was not due", m));
        end else begin
          check_mst($sformatf("m_b[%0d]", m), m_b[m], deliveries[idx].b);
          delivered[idx] = 1'b1;
        end
      end
      held[m]   = m_bvalid[m] & ~m_bready[m];
      held_b[m] = m_b[m];
    end
    if (decode_err) err_seen++;
    for (int s = 0; s < num_slv; s++) begin
      if (s_bvalid[s] && s_bready[s]) begin
        mst = int'(sv_b[s].ids.fld.mst);
        if (mst < num_mst && exp_pend[mst] == 0) begin
          report_failure($sformatf("slave %0d accepted with no finished burst", s));
        end else if (mst < num_mst) begin
          exp_pend[mst]--;
        end
        sv_valid[s] = 1'b0;
      end
    end
    for (int m = 0; m < num_mst; m++) begin
      if (w_last[m].valid && w_last[m].ready && w_last[m].last) exp_pend[m]++;
    end
  endtask

  task automatic run_entry(input int e);
    int cyc;
    cyc      = 0;
    err_seen = 0;
    for (int r = 0; r < n_raise; r++) begin
      if (int'(raises[r].ent) == e) begin
        sv_valid[raises[r].slv] = 1'b1;
        sv_b[raises[r].slv]     = raises[r].b;
      end
    end
    while (!entry_done(e) && cyc < max_wait) begin
      run_cycle(e, cyc);
      cyc++;
    end
    if (!entry_done(e)) begin
      n_timeout++;
      $display("%0t: entry %0d timed out waiting for its responses", $time, e);
    end
    repeat (quiet) begin
      run_cycle(e, cyc);
      cyc++;
    end
    check_err(err_seen, int'(entries[e].n_err));
  endtask

  initial begin
    rstn      = 1'b0;
    s_bvalid  = '0;
    s_b       = '0;
    m_bready  = '0;
    w_last    = '0;
    sv_valid  = '0;
    sv_b      = '0;
    held      = '0;
    held_b    = '0;
    delivered = '0;
    for (int m = 0; m < num_mst; m++) begin
      exp_pend[m] = 0;
    end
    repeat (8) @(negedge clk);
    rstn = 1'b1;
    #1;
    if (m_bvalid != '0 || s_bready != '0 || decode_err) begin
      report_failure("outputs not quiet after reset");
    end
    for (int e = 0; e < n_ent; e++) begin
      run_entry(e);
    end
    if (sv_valid != '0) report_failure("slave responses left unaccepted at the end");
    n_assert = u_axi_b_xbar.u_asserts.n_fail;
    $display("errors: %0d mismatch, %0d protocol, %0d timeout, %0d assertion",
             n_mismatch, n_proto, n_timeout, n_assert);
    if (n_mismatch + n_proto + n_timeout + n_assert == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+.
logic/axi_b_pkg.sv
logic/w_burst_tracker.sv
logic/b_arbiter.sv
logic/b_router.sv
logic/axi_b_xbar.sv
tb/axi_b_xbar_asserts.sv
tb/tb_axi_b_xbar.sv

// ==== Makefile ====
SIM       = verilator
FLAGS     = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_axi_b_xbar
FILELIST  = files.f
RUN_FLAGS = +verilator+error+limit+1000

OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(filter %.sv,$(shell cat $(FILELIST))) axi_params.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) $(RUN_FLAGS) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
